// File: cpu_testdata.txt
// Program length, program words, then count of outputs and expected out_data values.
// Instruction fields: cond op rd ra rb imm (4 4 4 4 4 12 bits).
00000024
// Clear R0, set R1 and R2, then ALU ops each followed by OUT.
020FF000 06100123 06200F0F 0B020000
01312000 0B030000 02312000 0B030000
03312000 0B030000 04312000 0B030000
05312000 0B030000
// Store R3 to word 80, load it into R4, emit R4.
08003080 07400080 0B040000
// Compare R1 with R2, then OUT of the PC under each condition.
09012000 1B0F0000 2B0F0000 3B0F0000 4B0F0000
5B0F0000 6B0F0000 7B0F0000 8B0F0000 9B0F0000
AB0F0000
// Counted loop from 3 down to 1 with a backward branch.
06500003 0B050000 06550FFF 09050000 2A000FFC
// Halt, then words that must never run.
0C000000 0B010000 0B0F0000
// Expected outputs.
0000000F
FFFFFF0F 00000032 00000214 00000103
FFFFFF2F FFFFFE2C
FFFFFE2C
00000014 00000015 00000017 0000001A 0000001C
00000003 00000002 00000001

// File: sim.f
cpu_pkg.sv
mem_unit.sv
reg_file.sv
alu.sv
bus_unit.sv
control.sv
cpu_top.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - mem_unit.sv
  - reg_file.sv
  - alu.sv
  - bus_unit.sv
  - control.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int          ADDR_WIDTH      = 8;
  localparam int          CLK_PERIOD      = 100;
  localparam int          RESET_CYCLES    = 16;
  localparam int          DATA_DEPTH      = 128;
  localparam int          CYCLES_PER_WORD = 40;
  localparam int          TIMEOUT_SCALE   = 4;
  localparam int          RUNS            = 2;
  localparam int          SETTLE_CYCLES   = 8;  // Watch for stray pulses after halt.
  localparam int unsigned SEED            = 32'h9a87d1e6;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic                  load_en;
  logic [ADDR_WIDTH-1:0] load_addr;
  word_t                 load_data;
  logic                  out_valid;
  word_t                 out_data;
  logic                  halted;

  word_t test_data [DATA_DEPTH];
  word_t program_words [$];
  word_t expected [$];
  int    out_index;
  int    run_count;
  bit    data_ready;

  cpu_top #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
    .clk, .rst, .start, .load_en, .load_addr, .load_data, .out_valid, .out_data, .halted
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  // **********************************************************************
  // Test data, program load and runs
  // **********************************************************************

  task automatic read_test_data();
    int n_words;
    int n_out;
    $readmemh("cpu_testdata.txt", test_data);
    n_words = int'(test_data[0]);
    assert (n_words > 0 && n_words < DATA_DEPTH - 1 && n_words <= 2**ADDR_WIDTH) else begin
      $display("Test data has no valid program length");
      abort_run();
    end
    n_out = int'(test_data[n_words + 1]);
    assert (n_out > 0 && n_words + n_out + 2 <= DATA_DEPTH) else begin
      $display("Test data has no valid count of expected outputs");
      abort_run();
    end
    for (int i = 0; i < n_words; i++) begin
      program_words.push_back(test_data[i + 1]);
    end
    for (int i = 0; i < n_out; i++) begin
      expected.push_back(test_data[n_words + 2 + i]);
    end
  endtask

  task automatic load_program();
    foreach (program_words[i]) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= ADDR_WIDTH'(i);
      load_data <= program_words[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic run_program();
    out_index = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    assert (!halted) else begin
      $display("Core did not leave the stopped state after start");
      abort_run();
    end
    while (!halted) @(negedge clk);
    repeat (SETTLE_CYCLES) @(negedge clk);
    assert (out_index == expected.size()) else begin
      $display("Run %0d halted after %0d of %0d outputs", run_count, out_index,
               expected.size());
      abort_run();
    end
    run_count++;
  endtask

  // **********************************************************************
  // Output checker and watchdog
  // **********************************************************************

  always @(negedge clk) begin
    if (!rst && out_valid) begin
      assert (out_index < expected.size()) else begin
        $display("Extra out_valid pulse in run %0d with data %h", run_count, out_data);
        abort_run();
      end
      assert (out_data === expected[out_index]) else begin
        $display("Mismatch out_data: expected %h, got %h (output %0d, run %0d)",
                 expected[out_index], out_data, out_index, run_count);
        abort_run();
      end
      out_index++;
    end
  end

  initial begin
    wait (data_ready);
    repeat (program_words.size() * CYCLES_PER_WORD * TIMEOUT_SCALE) @(posedge clk);
    $display("Timeout, the program never halted in run %0d", run_count);
    abort_run();
  end

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    out_index  = 0;
    run_count  = 0;
    data_ready = 1'b0;
    void'($urandom(SEED));
    read_test_data();
    data_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (halted && !out_valid) else begin
      $display("Core not stopped and idle after reset");
      abort_run();
    end

    load_program();
    for (int r = 0; r < RUNS; r++) begin
      repeat ($urandom_range(1, 6)) @(posedge clk);  // Idle gap before start.
      run_program();
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  load_en,
  input  logic [ADDR_WIDTH-1:0] load_addr,
  input  cpu_pkg::word_t        load_data,
  output logic                  out_valid,
  output cpu_pkg::word_t        out_data,
  output logic                  halted
);
  import cpu_pkg::*;

  ctrl_t   ctrl;
  word_t   bus_a;
  word_t   bus_b;
  word_t   rd_a;
  word_t   rd_b;
  word_t   mem_data;
  word_t   mar;
  word_t   mdr;
  word_t   alu_result;
  status_t alu_flags;
  status_t status;
  ir_t     ir;

  mem_unit #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
    .clk, .rst, .load_en, .load_addr, .load_data, .ctrl, .bus_b,
    .alu_result, .mem_data, .mar, .mdr
  );

  reg_file u_regs (
    .clk, .rst, .ctrl, .wr_data(alu_result), .start, .rd_a, .rd_b
  );

  alu u_alu (.op(ctrl.alu_op), .a(bus_a), .b(bus_b), .result(alu_result), .flags(alu_flags));

  bus_unit u_bus (
    .clk, .rst, .ctrl, .rd_a, .rd_b, .mdr, .mar, .mem_data, .alu_flags,
    .bus_a, .bus_b, .ir, .status, .out_valid, .out_data
  );

  control u_ctrl (.clk, .rst, .start, .ir, .status, .ctrl, .halted);

endmodule

// File: control.sv
`timescale 1ns/100ps

module control (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  cpu_pkg::ir_t     ir,
  input  cpu_pkg::status_t status,
  output cpu_pkg::ctrl_t   ctrl,
  output logic             halted
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    STOP, FETCH, DECODE, EXEC, ADDR, MEM, WB
  } state_e;

  state_e state;

  function automatic logic cond_ok(cond_e cond, status_t st);
    case (cond)
      NONE:    cond_ok = 1'b1;
      EQ:      cond_ok = st.zero;
      NE:      cond_ok = !st.zero;
      LTU:     cond_ok = !st.carry;
      GTU:     cond_ok = st.carry && !st.zero;
      LEU:     cond_ok = !st.carry || st.zero;
      GEU:     cond_ok = st.carry;
      LTS:     cond_ok = st.negative != st.overflow;
      GTS:     cond_ok = !st.zero && (st.negative == st.overflow);
      LES:     cond_ok = st.zero || (st.negative != st.overflow);
      GES:     cond_ok = st.negative == st.overflow;
      default: cond_ok = 1'b1;
    endcase
  endfunction

  assign halted = state == STOP;

  // ********************************************************************
  // State sequencing
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= STOP;
    end else begin
      case (state)
        STOP:   if (start) state <= FETCH;
        FETCH:  state <= DECODE;
        DECODE: begin
          if (!cond_ok(ir.cond, status)) begin
            state <= FETCH;  // Skipped.
          end else begin
            case (ir.opcode)
              HALT:    state <= STOP;
              LD, ST:  state <= ADDR;
              NOP:     state <= FETCH;
              ADD, SUB, AND_OP, OR_OP, XOR_OP, ADDI, CMP, B, OUT: state <= EXEC;
              default: state <= FETCH;
            endcase
          end
        end
        ADDR:    state <= MEM;
        MEM:     state <= (ir.opcode == LD) ? WB : FETCH;
        default: state <= FETCH;  // EXEC and WB.
      endcase
    end
  end

  // ********************************************************************
  // Control word
  // ********************************************************************

  always_comb begin
    ctrl = '0;
    case (state)
      FETCH: begin
        ctrl.sel_b_reg_file   = PC;  // ir <= [pc], pc <= pc + 1.
        ctrl.oe_b_reg_file    = 1'b1;
        ctrl.mem_rd           = 1'b1;
        ctrl.ld_ir            = 1'b1;
        ctrl.count_b_reg_file = 2'd1;
      end
      EXEC: begin
        ctrl.oe_a_reg_file  = 1'b1;
        ctrl.sel_a_reg_file = ir.ra;
        ctrl.sel_b_reg_file = ir.rb;
        ctrl.sel_d_reg_file = ir.rd;
        case (ir.opcode)
          ADD, SUB, AND_OP, OR_OP, XOR_OP: begin
            ctrl.oe_b_reg_file = 1'b1;
            ctrl.oe_alu        = 1'b1;
            ctrl.ld_reg_file   = 1'b1;
            case (ir.opcode)
              ADD:     ctrl.alu_op = ALU_ADD;
              SUB:     ctrl.alu_op = ALU_SUB;
              AND_OP:  ctrl.alu_op = ALU_AND;
              OR_OP:   ctrl.alu_op = ALU_OR;
              default: ctrl.alu_op = ALU_XOR;
            endcase
          end
          ADDI: begin
            ctrl.oe_imm      = 1'b1;
            ctrl.alu_op      = ALU_ADD;
            ctrl.oe_alu      = 1'b1;
            ctrl.ld_reg_file = 1'b1;
          end
          CMP: begin
            ctrl.oe_b_reg_file = 1'b1;
            ctrl.alu_op        = ALU_SUB;
            ctrl.ld_status     = 1'b1;  // Flags only.
          end
          B: begin
            ctrl.sel_a_reg_file = PC;  // pc <= pc + imm.
            ctrl.sel_d_reg_file = PC;
            ctrl.oe_imm         = 1'b1;
            ctrl.alu_op         = ALU_ADD;
            ctrl.oe_alu         = 1'b1;
            ctrl.ld_reg_file    = 1'b1;
          end
          OUT:     ctrl.ld_out = 1'b1;
          default: ctrl.oe_a_reg_file = 1'b0;
        endcase
      end
      ADDR: begin
        ctrl.oe_a_reg_file  = 1'b1;  // mar <= ra + imm.
        ctrl.sel_a_reg_file = ir.ra;
        ctrl.oe_imm         = 1'b1;
        ctrl.alu_op         = ALU_ADD;
        ctrl.oe_alu         = 1'b1;
        ctrl.ld_mar         = 1'b1;
      end
      MEM: begin
        ctrl.oe_mar = 1'b1;
        if (ir.opcode == LD) begin
          ctrl.mem_rd = 1'b1;
          ctrl.ld_mdr = 1'b1;
        end else begin
          ctrl.mem_wr         = 1'b1;  // Store data through the ALU.
          ctrl.oe_a_reg_file  = 1'b1;
          ctrl.sel_a_reg_file = ir.rb;
          ctrl.alu_op         = ALU_PASS_A;
          ctrl.oe_alu         = 1'b1;
        end
      end
      WB: begin
        ctrl.oe_mdr         = 1'b1;
        ctrl.alu_op         = ALU_PASS_A;
        ctrl.oe_alu         = 1'b1;
        ctrl.ld_reg_file    = 1'b1;
        ctrl.sel_d_reg_file = ir.rd;
      end
      default: ctrl = '0;  // STOP and DECODE.
    endcase
  end

endmodule

// File: bus_unit.sv
`timescale 1ns/100ps

module bus_unit (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::word_t   rd_a,
  input  cpu_pkg::word_t   rd_b,
  input  cpu_pkg::word_t   mdr,
  input  cpu_pkg::word_t   mar,
  input  cpu_pkg::word_t   mem_data,
  input  cpu_pkg::status_t alu_flags,
  output cpu_pkg::word_t   bus_a,
  output cpu_pkg::word_t   bus_b,
  output cpu_pkg::ir_t     ir,
  output cpu_pkg::status_t status,
  output logic             out_valid,
  output cpu_pkg::word_t   out_data
);
  import cpu_pkg::*;

  a_src_e a_src;
  b_src_e b_src;
  word_t  imm_ext;

  assign imm_ext = {{(WORD_WIDTH-IMM_WIDTH){ir.imm[IMM_WIDTH-1]}}, ir.imm};

  // ********************************************************************
  // Bus drivers
  // ********************************************************************

  always_comb begin
    a_src = A_NONE;
    if (ctrl.oe_a_reg_file) a_src = A_REG;
    else if (ctrl.oe_mdr) a_src = A_MDR;

    b_src = B_NONE;
    if (ctrl.oe_b_reg_file) b_src = B_REG;
    else if (ctrl.oe_imm) b_src = B_IMM;
    else if (ctrl.oe_mar) b_src = B_MAR;
  end

  always_comb begin
    case (a_src)
      A_REG:   bus_a = rd_a;
      A_MDR:   bus_a = mdr;
      default: bus_a = '0;  // Idle bus reads zero.
    endcase
    case (b_src)
      B_REG:   bus_b = rd_b;
      B_IMM:   bus_b = imm_ext;
      B_MAR:   bus_b = mar;
      default: bus_b = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      status    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (ctrl.ld_status) status <= alu_flags;
      out_valid <= ctrl.ld_out;
    end
    if (ctrl.ld_ir) ir <= ir_t'(mem_data);
    if (ctrl.ld_out) out_data <= bus_a;
  end

  a_bus_a_one: assert property (
    @(posedge clk) disable iff (rst) $onehot0({ctrl.oe_a_reg_file, ctrl.oe_mdr})
  ) else $error("bus A has more than one driver");

  a_bus_b_one: assert property (
    @(posedge clk) disable iff (rst)
      $onehot0({ctrl.oe_b_reg_file, ctrl.oe_imm, ctrl.oe_mar})
  ) else $error("bus B has more than one driver");

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result,
  output cpu_pkg::status_t flags
);
  import cpu_pkg::*;

  localparam int MSB = WORD_WIDTH - 1;

  logic [WORD_WIDTH:0] sum;  // Carry in top bit.

  always_comb begin
    sum            = '0;
    result         = '0;
    flags          = '0;

    case (op)
      ALU_PASS_A: begin
        result = a;
      end
      ALU_ADD: begin
        sum            = {1'b0, a} + {1'b0, b};
        result         = sum[MSB:0];
        flags.carry    = sum[WORD_WIDTH];
        flags.overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      end
      ALU_SUB: begin
        // a + ~b + 1, carry set when no borrow.
        sum            = {1'b0, a} + {1'b0, ~b} + 1'b1;
        result         = sum[MSB:0];
        flags.carry    = sum[WORD_WIDTH];
        flags.overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      default: begin
        result = a;
      end
    endcase

    flags.zero     = result == '0;
    flags.negative = result[MSB];
  end

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic           clk,
  input  logic           rst,
  input  cpu_pkg::ctrl_t ctrl,
  input  cpu_pkg::word_t wr_data,
  input  logic           start,
  output cpu_pkg::word_t rd_a,
  output cpu_pkg::word_t rd_b
);
  import cpu_pkg::*;

  word_t regs [16];
  logic  wr_en;
  logic  count_en;

  assign wr_en    = ctrl.ld_reg_file && ctrl.oe_alu;
  assign count_en = ctrl.count_b_reg_file != '0;

  // Read ports.
  assign rd_a = regs[ctrl.sel_a_reg_file];
  assign rd_b = regs[ctrl.sel_b_reg_file];

  // ********************************************************************
  // Write port and in-place counter
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[ctrl.sel_d_reg_file] <= wr_data;
    end else if (count_en) begin
      regs[ctrl.sel_b_reg_file] <= rd_b + word_t'(ctrl.count_b_reg_file);
    end

    // Restart from address 0.
    if (rst || start) begin
      regs[PC] <= '0;
    end
  end

endmodule

// File: mem_unit.sv
`timescale 1ns/100ps

module mem_unit #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load_en,
  input  logic [ADDR_WIDTH-1:0] load_addr,
  input  cpu_pkg::word_t        load_data,
  input  cpu_pkg::ctrl_t        ctrl,
  input  cpu_pkg::word_t        bus_b,
  input  cpu_pkg::word_t        alu_result,
  output cpu_pkg::word_t        mem_data,
  output cpu_pkg::word_t        mar,
  output cpu_pkg::word_t        mdr
);
  import cpu_pkg::*;

  word_t                 mem [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] core_addr;

  assign core_addr = bus_b[ADDR_WIDTH-1:0];  // Word address.

  // Asynchronous read port.
  assign mem_data = ctrl.mem_rd ? mem[core_addr] : '0;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // Host port wins.
    end else if (ctrl.mem_wr) begin
      mem[core_addr] <= alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ld_mar && ctrl.oe_alu) begin
      mar <= alu_result;
    end
    if (ctrl.ld_mdr) begin
      mdr <= mem_data;
    end
  end

  // ********************************************************************
  // Checks
  // ********************************************************************

  a_rd_wr_excl: assert property (
    @(posedge clk) disable iff (rst) !(ctrl.mem_rd && ctrl.mem_wr)
  ) else $error("mem_rd and mem_wr high together");

  // Host loads only while the core leaves memory alone.
  a_host_idle: assert property (
    @(posedge clk) disable iff (rst) load_en |-> !(ctrl.mem_rd || ctrl.mem_wr)
  ) else $error("host load during core memory access");

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_WIDTH = 32;
  localparam int IMM_WIDTH  = 12;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // ********************************************************************
  // Encodings
  // ********************************************************************

  typedef enum logic [3:0] {
    NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
  } cond_e;

  typedef enum logic [3:0] {
    NOP, ADD, SUB, AND_OP, OR_OP, XOR_OP, ADDI, LD, ST, CMP, B, OUT, HALT
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_PASS_A, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
  } alu_op_e;

  typedef enum logic [3:0] {
    R0, R1, R2, R3, R4, R5, R6, R7,
    R8, R9, R10, R11, R12, R13, R14, PC
  } reg_e;

  typedef enum logic [1:0] {A_REG, A_MDR, A_NONE} a_src_e;
  typedef enum logic [1:0] {B_REG, B_IMM, B_MAR, B_NONE} b_src_e;

  // ********************************************************************
  // Instruction, flags and control word
  // ********************************************************************

  typedef struct packed {
    cond_e                cond;
    opcode_e              opcode;
    reg_e                 rd;
    reg_e                 ra;
    reg_e                 rb;
    logic [IMM_WIDTH-1:0] imm;    // Signed offset.
  } ir_t;

  typedef struct packed {
    logic zero;
    logic carry;
    logic negative;
    logic overflow;
  } status_t;

  typedef struct packed {
    logic       mem_rd;
    logic       mem_wr;
    logic       oe_a_reg_file;
    logic       oe_b_reg_file;
    logic       ld_reg_file;
    reg_e       sel_a_reg_file;
    reg_e       sel_b_reg_file;
    reg_e       sel_d_reg_file;
    logic [1:0] count_b_reg_file;  // Added in place to port B register.
    logic       oe_imm;
    logic       ld_ir;
    logic       ld_status;
    logic       ld_mdr;
    logic       oe_mdr;
    logic       ld_mar;
    logic       oe_mar;
    logic       oe_alu;
    alu_op_e    alu_op;
    logic       ld_out;
  } ctrl_t;

endpackage
